/* logic/sdram_sched_pkg.sv */
`default_nettype none

package sdram_sched_pkg;

  // SDRAM geometry
  localparam int DQ_W      = 16;
  localparam int BA_W      = 2;
  localparam int ROW_W     = 13;
  localparam int COL_W     = 10;
  localparam int BANKS     = 4;
  localparam int BURST_LEN = 4;

  // Timing fields and read tag port index, up to 8 ports
  localparam int TCNT_W     = 6;
  localparam int PORT_IDX_W = 3;

  typedef logic [DQ_W-1:0]             dq_t;
  typedef logic [DQ_W/8-1:0]           dm_t;
  typedef logic [BA_W-1:0]             ba_t;
  typedef logic [ROW_W-1:0]            row_t;
  typedef logic [COL_W-1:0]            col_t;
  typedef logic [ROW_W-1:0]            sdram_addr_t;
  typedef logic [BURST_LEN*DQ_W-1:0]   wdata_t;
  typedef logic [BURST_LEN*DQ_W/8-1:0] wbe_t;
  typedef logic [TCNT_W-1:0]           cnt_t;
  typedef logic [PORT_IDX_W-1:0]       port_idx_t;

  // CS_n RAS_n CAS_n WE_n
  typedef enum logic [3:0] {
    CMD_NOP = 4'b0111,
    CMD_ACT = 4'b0011,
    CMD_RD  = 4'b0101,
    CMD_WR  = 4'b0100,
    CMD_PRE = 4'b0010,
    CMD_REF = 4'b0001
  } sdram_cmd_e;

  typedef enum logic {
    BANK_IDLE   = 1'b0,
    BANK_ACTIVE = 1'b1
  } bank_state_e;

  typedef struct packed {
    cnt_t        t_ras;
    cnt_t        t_rp;
    cnt_t        t_rcd;
    cnt_t        t_rc;
    cnt_t        cl;
    cnt_t        t_rdv;
    logic [15:0] t_ref;
    logic        ena;
  } timing_t;

  typedef struct packed {
    ba_t  ba;
    row_t row;
    col_t col;
  } req_t;

  typedef struct packed {
    logic      valid;
    port_idx_t port;
  } rd_tag_t;

endpackage

`default_nettype wire

/* logic/bank_timers.sv */
`default_nettype none

module bank_timers
  import sdram_sched_pkg::*;
(
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire timing_t          timing_i,
  input  wire logic [BANKS-1:0] act_ld_i,
  input  wire logic [BANKS-1:0] pre_ld_i,
  input  wire logic             ref_ld_i,
  output logic [BANKS-1:0]      ras_done_o,
  output logic [BANKS-1:0]      rp_done_o,
  output logic [BANKS-1:0]      rcd_done_o,
  output logic                  rc_done_o
);

  cnt_t ras_cnt [BANKS];
  cnt_t rp_cnt  [BANKS];
  cnt_t rcd_cnt [BANKS];
  cnt_t rc_cnt;

  // One step of a loadable down-counter that stops at zero
  function automatic cnt_t cnt_step(input cnt_t cnt, input logic ld, input cnt_t val);
    cnt_t nxt;
    if (ld)
      nxt = val;
    else if (cnt != '0)
      nxt = cnt - 1'b1;
    else
      nxt = cnt;
    return nxt;
  endfunction

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      for (int b = 0; b < BANKS; b++)
      begin
        ras_cnt[b] <= '0;
        rp_cnt[b]  <= '0;
        rcd_cnt[b] <= '0;
      end
      rc_cnt <= '0;
    end
    else
    begin
      for (int b = 0; b < BANKS; b++)
      begin
        ras_cnt[b] <= cnt_step(ras_cnt[b], act_ld_i[b], timing_i.t_ras);
        rcd_cnt[b] <= cnt_step(rcd_cnt[b], act_ld_i[b], timing_i.t_rcd);
        rp_cnt[b]  <= cnt_step(rp_cnt[b], pre_ld_i[b], timing_i.t_rp);
      end
      // Row cycle is shared by all banks
      rc_cnt <= cnt_step(rc_cnt, ref_ld_i | (|act_ld_i), timing_i.t_rc);
    end
  end

  always_comb
  begin
    for (int b = 0; b < BANKS; b++)
    begin
      ras_done_o[b] = (ras_cnt[b] == '0);
      rp_done_o[b]  = (rp_cnt[b] == '0);
      rcd_done_o[b] = (rcd_cnt[b] == '0);
    end
    rc_done_o = (rc_cnt == '0);
  end

endmodule

`default_nettype wire

/* logic/refresh_tracker.sv */
`default_nettype none

module refresh_tracker
  import sdram_sched_pkg::*;
(
  input  wire logic    clk_i,
  input  wire logic    rst_ni,
  input  wire timing_t timing_i,
  input  wire logic    ref_issued_i,
  output logic         ref_pending_o,
  output logic         ref_urgent_o
);

  logic [15:0] intv_cnt;
  logic        armed;
  logic        expired;
  logic [2:0]  pend_cnt;

  assign expired = timing_i.ena && armed && (intv_cnt == '0);

  // Interval counter, first load when enabled
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      intv_cnt <= '0;
      armed    <= 1'b0;
    end
    else if (timing_i.ena)
    begin
      armed <= 1'b1;
      if (!armed || expired)
        intv_cnt <= timing_i.t_ref;
      else
        intv_cnt <= intv_cnt - 1'b1;
    end
  end

  // Pending refreshes, saturating
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      pend_cnt <= '0;
    else
    begin
      case ({expired, ref_issued_i})
        2'b10:
          if (pend_cnt != '1)
            pend_cnt <= pend_cnt + 1'b1;
        2'b01:
          if (pend_cnt != '0)
            pend_cnt <= pend_cnt - 1'b1;
        default:
          pend_cnt <= pend_cnt;
      endcase
    end
  end

  assign ref_pending_o = |pend_cnt;
  assign ref_urgent_o  = &pend_cnt;

endmodule

`default_nettype wire

/* logic/cmd_scheduler.sv */
`default_nettype none

module cmd_scheduler
  import sdram_sched_pkg::*;
#(
  parameter int PORTS = 2
)
(
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire timing_t          timing_i,
  input  wire logic [PORTS-1:0] rd_req_i,
  input  wire logic [PORTS-1:0] wr_req_i,
  input  wire req_t             rd_addr_i [PORTS],
  input  wire req_t             wr_addr_i [PORTS],
  input  wire wdata_t           wr_data_i [PORTS],
  input  wire wbe_t             wr_be_i   [PORTS],
  input  wire logic [BANKS-1:0] ras_done_i,
  input  wire logic [BANKS-1:0] rp_done_i,
  input  wire logic [BANKS-1:0] rcd_done_i,
  input  wire logic             rc_done_i,
  input  wire logic             ref_pending_i,
  input  wire logic             ref_urgent_i,
  output logic [BANKS-1:0]      act_ld_o,
  output logic [BANKS-1:0]      pre_ld_o,
  output logic                  ref_ld_o,
  output rd_tag_t               rd_tag_o,
  output logic                  wr_load_o,
  output wdata_t                wr_data_o,
  output wbe_t                  wr_be_o,
  output logic [PORTS-1:0]      rd_rdy_o,
  output logic [PORTS-1:0]      wr_rdy_o,
  output sdram_cmd_e            sdram_cmd_o,
  output ba_t                   sdram_ba_o,
  output sdram_addr_t           sdram_addr_o
);

  localparam int PORT_W = (PORTS > 1) ? $clog2(PORTS) : 1;
  localparam int GAP_W  = TCNT_W + 2;
  // A10 selects all banks on PRE
  localparam int AP_BIT = 10;

  typedef enum logic {
    ST_IDLE,
    ST_REF_WAIT
  } state_e;

  state_e            state;
  state_e            state_nxt;
  bank_state_e       bank_st  [BANKS];
  row_t              bank_row [BANKS];

  logic [PORTS-1:0]  rd_pend;
  logic [PORTS-1:0]  wr_pend;
  logic [PORT_W-1:0] rd_port;
  logic [PORT_W-1:0] wr_port;
  logic [PORT_W-1:0] sel_port;
  logic              sel_valid;
  logic              sel_wr;
  logic              sel_hit;
  req_t              sel_req;

  logic [GAP_W-1:0]  gap_cnt;
  logic [GAP_W-1:0]  rd2wr_cnt;
  logic              gap_done;
  logic              rd2wr_done;
  logic              all_idle;
  logic              act_ras_done;
  logic              issue_rd;
  logic              issue_wr;

  sdram_cmd_e        cmd_nxt;
  ba_t               ba_nxt;
  sdram_addr_t       addr_nxt;

  // Lowest set bit wins, port 0 first
  function automatic logic [PORT_W-1:0] first_set(input logic [PORTS-1:0] vec);
    logic [PORT_W-1:0] idx;
    idx = '0;
    for (int p = PORTS - 1; p >= 0; p--)
    begin
      if (vec[p])
        idx = PORT_W'(p);
    end
    return idx;
  endfunction

  ////////////////////
  // Request selection
  ////////////////////

  // Requests still high in their ready cycle are not taken again
  assign rd_pend   = rd_req_i & ~rd_rdy_o;
  assign wr_pend   = wr_req_i & ~wr_rdy_o;
  assign rd_port   = first_set(rd_pend);
  assign wr_port   = first_set(wr_pend);

  // Writes before reads
  assign sel_wr    = |wr_pend;
  assign sel_valid = (|wr_pend) || (|rd_pend);
  assign sel_port  = sel_wr ? wr_port : rd_port;
  assign sel_req   = sel_wr ? wr_addr_i[wr_port] : rd_addr_i[rd_port];
  assign sel_hit   = (bank_st[sel_req.ba] == BANK_ACTIVE)
                  && (bank_row[sel_req.ba] == sel_req.row);

  always_comb
  begin
    all_idle     = 1'b1;
    act_ras_done = 1'b1;
    for (int b = 0; b < BANKS; b++)
    begin
      if (bank_st[b] == BANK_ACTIVE)
      begin
        all_idle = 1'b0;
        if (!ras_done_i[b])
          act_ras_done = 1'b0;
      end
    end
  end

  ////////////////////
  // Burst spacing
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      gap_cnt   <= '0;
      rd2wr_cnt <= '0;
    end
    else
    begin
      if (issue_rd || issue_wr)
        gap_cnt <= GAP_W'(BURST_LEN - 1);
      else if (gap_cnt != '0)
        gap_cnt <= gap_cnt - 1'b1;

      // Read data strobes trail the bus by t_rdv
      if (issue_rd)
        rd2wr_cnt <= GAP_W'(BURST_LEN - 1) + GAP_W'(timing_i.cl) + GAP_W'(timing_i.t_rdv);
      else if (rd2wr_cnt != '0)
        rd2wr_cnt <= rd2wr_cnt - 1'b1;
    end
  end

  assign gap_done   = (gap_cnt == '0);
  assign rd2wr_done = (rd2wr_cnt == '0);

  ////////////////////
  // Command decision
  ////////////////////

  always_comb
  begin
    state_nxt = state;
    cmd_nxt   = CMD_NOP;
    ba_nxt    = '0;
    addr_nxt  = '0;
    act_ld_o  = '0;
    pre_ld_o  = '0;
    ref_ld_o  = 1'b0;
    issue_rd  = 1'b0;
    issue_wr  = 1'b0;

    case (state)
      ST_IDLE:
      begin
        if (ref_urgent_i || (ref_pending_i && !sel_valid))
        begin
          if (all_idle)
          begin
            if ((&rp_done_i) && rc_done_i)
            begin
              cmd_nxt  = CMD_REF;
              ref_ld_o = 1'b1;
            end
          end
          else if (act_ras_done && gap_done)
          begin
            // Close every bank before refresh
            cmd_nxt          = CMD_PRE;
            addr_nxt[AP_BIT] = 1'b1;
            pre_ld_o         = '1;
            if (ref_urgent_i)
              state_nxt = ST_REF_WAIT;
          end
        end
        else if (sel_valid)
        begin
          if (sel_hit)
          begin
            if (rcd_done_i[sel_req.ba] && gap_done && (!sel_wr || rd2wr_done))
            begin
              cmd_nxt  = sel_wr ? CMD_WR : CMD_RD;
              ba_nxt   = sel_req.ba;
              addr_nxt = sdram_addr_t'(sel_req.col);
              issue_wr = sel_wr;
              issue_rd = !sel_wr;
            end
          end
          else if (bank_st[sel_req.ba] == BANK_IDLE)
          begin
            if (rp_done_i[sel_req.ba] && rc_done_i)
            begin
              cmd_nxt              = CMD_ACT;
              ba_nxt               = sel_req.ba;
              addr_nxt             = sel_req.row;
              act_ld_o[sel_req.ba] = 1'b1;
            end
          end
          else if (ras_done_i[sel_req.ba] && gap_done)
          begin
            // Row miss
            cmd_nxt              = CMD_PRE;
            ba_nxt               = sel_req.ba;
            pre_ld_o[sel_req.ba] = 1'b1;
          end
        end
      end

      ST_REF_WAIT:
      begin
        if ((&rp_done_i) && rc_done_i)
        begin
          cmd_nxt   = CMD_REF;
          ref_ld_o  = 1'b1;
          state_nxt = ST_IDLE;
        end
      end

      default:
        state_nxt = ST_IDLE;
    endcase
  end

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state       <= ST_IDLE;
      sdram_cmd_o <= CMD_NOP;
      rd_rdy_o    <= '0;
      wr_rdy_o    <= '0;
      for (int b = 0; b < BANKS; b++)
        bank_st[b] <= BANK_IDLE;
    end
    else
    begin
      state       <= state_nxt;
      sdram_cmd_o <= cmd_nxt;
      rd_rdy_o    <= issue_rd ? (PORTS'(1) << sel_port) : '0;
      wr_rdy_o    <= issue_wr ? (PORTS'(1) << sel_port) : '0;
      for (int b = 0; b < BANKS; b++)
      begin
        if (act_ld_o[b])
          bank_st[b] <= BANK_ACTIVE;
        else if (pre_ld_o[b])
          bank_st[b] <= BANK_IDLE;
      end
    end
  end

  // Open rows and address pins
  always_ff @(posedge clk_i)
  begin
    for (int b = 0; b < BANKS; b++)
    begin
      if (act_ld_o[b])
        bank_row[b] <= sel_req.row;
    end
    sdram_ba_o   <= ba_nxt;
    sdram_addr_o <= addr_nxt;
  end

  // Read tag and write burst go out with the decision
  assign rd_tag_o.valid = issue_rd;
  assign rd_tag_o.port  = port_idx_t'(rd_port);
  assign wr_load_o      = issue_wr;
  assign wr_data_o      = wr_data_i[wr_port];
  assign wr_be_o        = wr_be_i[wr_port];

endmodule

`default_nettype wire

/* logic/rd_valid_pipe.sv */
`default_nettype none

module rd_valid_pipe
  import sdram_sched_pkg::*;
#(
  parameter int PORTS = 2
)
(
  input  wire logic        clk_i,
  input  wire logic        rst_ni,
  input  wire timing_t     timing_i,
  input  wire rd_tag_t     rd_tag_i,
  output logic [PORTS-1:0] rd_valid_o
);

  localparam int PORT_W   = (PORTS > 1) ? $clog2(PORTS) : 1;
  // Longest cl + t_rdv the line holds
  localparam int LINE_LEN = 32;
  localparam int POS_W    = $clog2(LINE_LEN);
  localparam int DLY_W    = TCNT_W + 1;
  localparam int BEAT_W   = $clog2(BURST_LEN + 1);

  rd_tag_t           tag_line [LINE_LEN];
  logic [DLY_W-1:0]  dly;
  logic [POS_W-1:0]  wr_pos;
  logic [BEAT_W-1:0] beat_cnt;
  logic [PORT_W-1:0] cur_port;

  assign dly    = DLY_W'(timing_i.cl) + DLY_W'(timing_i.t_rdv);
  assign wr_pos = (dly > DLY_W'(LINE_LEN - 1)) ? POS_W'(LINE_LEN - 1) : dly[POS_W-1:0];

  // Tags enter at cl + t_rdv and move towards entry 0
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      for (int i = 0; i < LINE_LEN; i++)
        tag_line[i] <= '0;
    end
    else
    begin
      for (int i = 0; i < LINE_LEN - 1; i++)
        tag_line[i] <= tag_line[i + 1];
      tag_line[LINE_LEN - 1] <= '0;
      if (rd_tag_i.valid)
        tag_line[wr_pos] <= rd_tag_i;
    end
  end

  // Remaining beats after the head
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      beat_cnt <= '0;
      cur_port <= '0;
    end
    else if (tag_line[0].valid)
    begin
      beat_cnt <= BEAT_W'(BURST_LEN - 1);
      cur_port <= tag_line[0].port[PORT_W-1:0];
    end
    else if (beat_cnt != '0)
      beat_cnt <= beat_cnt - 1'b1;
  end

  always_comb
  begin
    for (int p = 0; p < PORTS; p++)
    begin
      rd_valid_o[p] = (tag_line[0].valid && (tag_line[0].port == port_idx_t'(p)))
                   || ((beat_cnt != '0) && (cur_port == PORT_W'(p)));
    end
  end

endmodule

`default_nettype wire

/* logic/wr_data_shifter.sv */
`default_nettype none

module wr_data_shifter
  import sdram_sched_pkg::*;
(
  input  wire logic   clk_i,
  input  wire logic   rst_ni,
  input  wire logic   wr_load_i,
  input  wire wdata_t wr_data_i,
  input  wire wbe_t   wr_be_i,
  output dq_t         sdram_dq_o,
  output dm_t         sdram_dm_o,
  output logic        sdram_dqoe_o
);

  localparam int BEAT_W = $clog2(BURST_LEN + 1);

  wdata_t            dq_buf;
  wbe_t              dm_buf;
  logic [BEAT_W-1:0] beat_cnt;

  // Lowest beat goes out first
  always_ff @(posedge clk_i)
  begin
    if (wr_load_i)
    begin
      dq_buf <= wr_data_i;
      dm_buf <= ~wr_be_i;
    end
    else
    begin
      dq_buf <= dq_buf >> $bits(dq_t);
      dm_buf <= dm_buf >> $bits(dm_t);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      beat_cnt <= '0;
    else if (wr_load_i)
      beat_cnt <= BEAT_W'(BURST_LEN);
    else if (beat_cnt != '0)
      beat_cnt <= beat_cnt - 1'b1;
  end

  assign sdram_dq_o   = dq_buf[$bits(dq_t)-1:0];
  assign sdram_dm_o   = dm_buf[$bits(dm_t)-1:0];
  assign sdram_dqoe_o = (beat_cnt != '0);

endmodule

`default_nettype wire

/* logic/sdram_sched_top.sv */
`default_nettype none

module sdram_sched_top
  import sdram_sched_pkg::*;
#(
  parameter int PORTS = 2
)
(
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire timing_t          timing_i,

  // Read ports
  input  wire logic [PORTS-1:0] rd_req_i,
  input  wire req_t             rd_addr_i [PORTS],
  output logic [PORTS-1:0]      rd_rdy_o,
  output dq_t                   rd_data_o [PORTS],
  output logic [PORTS-1:0]      rd_valid_o,

  // Write ports
  input  wire logic [PORTS-1:0] wr_req_i,
  input  wire req_t             wr_addr_i [PORTS],
  input  wire wdata_t           wr_data_i [PORTS],
  input  wire wbe_t             wr_be_i   [PORTS],
  output logic [PORTS-1:0]      wr_rdy_o,

  // SDRAM pins
  output sdram_cmd_e            sdram_cmd_o,
  output ba_t                   sdram_ba_o,
  output sdram_addr_t           sdram_addr_o,
  input  wire dq_t              sdram_dq_i,
  output dq_t                   sdram_dq_o,
  output dm_t                   sdram_dm_o,
  output logic                  sdram_dqoe_o
);

  logic [BANKS-1:0] act_ld;
  logic [BANKS-1:0] pre_ld;
  logic             ref_ld;
  logic [BANKS-1:0] ras_done;
  logic [BANKS-1:0] rp_done;
  logic [BANKS-1:0] rcd_done;
  logic             rc_done;
  logic             ref_pending;
  logic             ref_urgent;
  rd_tag_t          rd_tag;
  logic             wr_load;
  wdata_t           wr_data;
  wbe_t             wr_be;

  bank_timers u_bank_timers (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .timing_i   (timing_i),
    .act_ld_i   (act_ld),
    .pre_ld_i   (pre_ld),
    .ref_ld_i   (ref_ld),
    .ras_done_o (ras_done),
    .rp_done_o  (rp_done),
    .rcd_done_o (rcd_done),
    .rc_done_o  (rc_done)
  );

  refresh_tracker u_refresh_tracker (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .timing_i      (timing_i),
    .ref_issued_i  (ref_ld),
    .ref_pending_o (ref_pending),
    .ref_urgent_o  (ref_urgent)
  );

  cmd_scheduler #(
    .PORTS (PORTS)
  ) u_cmd_scheduler (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .timing_i      (timing_i),
    .rd_req_i      (rd_req_i),
    .wr_req_i      (wr_req_i),
    .rd_addr_i     (rd_addr_i),
    .wr_addr_i     (wr_addr_i),
    .wr_data_i     (wr_data_i),
    .wr_be_i       (wr_be_i),
    .ras_done_i    (ras_done),
    .rp_done_i     (rp_done),
    .rcd_done_i    (rcd_done),
    .rc_done_i     (rc_done),
    .ref_pending_i (ref_pending),
    .ref_urgent_i  (ref_urgent),
    .act_ld_o      (act_ld),
    .pre_ld_o      (pre_ld),
    .ref_ld_o      (ref_ld),
    .rd_tag_o      (rd_tag),
    .wr_load_o     (wr_load),
    .wr_data_o     (wr_data),
    .wr_be_o       (wr_be),
    .rd_rdy_o      (rd_rdy_o),
    .wr_rdy_o      (wr_rdy_o),
    .sdram_cmd_o   (sdram_cmd_o),
    .sdram_ba_o    (sdram_ba_o),
    .sdram_addr_o  (sdram_addr_o)
  );

  rd_valid_pipe #(
    .PORTS (PORTS)
  ) u_rd_valid_pipe (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .timing_i   (timing_i),
    .rd_tag_i   (rd_tag),
    .rd_valid_o (rd_valid_o)
  );

  wr_data_shifter u_wr_data_shifter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wr_load_i    (wr_load),
    .wr_data_i    (wr_data),
    .wr_be_i      (wr_be),
    .sdram_dq_o   (sdram_dq_o),
    .sdram_dm_o   (sdram_dm_o),
    .sdram_dqoe_o (sdram_dqoe_o)
  );

  // Every port sees DQ, rd_valid_o marks the owner
  always_comb
  begin
    for (int p = 0; p < PORTS; p++)
      rd_data_o[p] = sdram_dq_i;
  end

endmodule

`default_nettype wire

/* tb/tb_sdram_sched.sv */
`default_nettype none

module tb_sdram_sched
  import sdram_sched_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int PORTS       = 2;
  localparam int N_TXN       = 60;
  localparam int WAIT_LIMIT  = 3000;
  localparam int RUN_LIMIT   = 20000;
  localparam int DRAIN_LIMIT = 200;
  localparam int T_RAS       = 6;
  localparam int T_RP        = 3;
  localparam int T_RCD       = 3;
  localparam int T_RC        = 8;
  localparam int T_CL        = 3;
  localparam int T_RDV       = 2;
  localparam int T_REF       = 99;
  // Pending refresh count saturates here
  localparam int REF_SAT     = 7;
  localparam int K_NONE      = 0;
  localparam int K_RD        = 1;
  localparam int K_WR        = 2;

  typedef struct packed {
    int start;
    int port;
  } rd_win_t;

  typedef struct packed {
    int  at;
    dq_t dq;
    dm_t dm;
  } wr_beat_t;

  logic             clk_i;
  logic             rst_ni;
  timing_t          timing;
  logic [PORTS-1:0] rd_req;
  logic [PORTS-1:0] wr_req;
  req_t             rd_addr [PORTS];
  req_t             wr_addr [PORTS];
  wdata_t           wr_data [PORTS];
  wbe_t             wr_be   [PORTS];
  logic [PORTS-1:0] rd_rdy;
  logic [PORTS-1:0] wr_rdy;
  logic [PORTS-1:0] rd_valid;
  dq_t              rd_data [PORTS];
  sdram_cmd_e       sdram_cmd;
  ba_t              sdram_ba;
  sdram_addr_t      sdram_addr;
  dq_t              dq_in;
  dq_t              dq_out;
  dm_t              dm_out;
  logic             dqoe;

  // Stimulus state per port
  int               seed = 32'h8711_9c65;
  int               kind      [PORTS];
  int               remaining [PORTS];
  int               gap       [PORTS];
  int               waited    [PORTS];
  logic             seen_rdy  [PORTS];
  req_t             cur_req   [PORTS];
  logic             aborted;

  // Bank and timing model
  int               cyc;
  int               n_errors;
  int               n_reads;
  int               n_writes;
  int               n_refs;
  logic [PORTS-1:0] prev_rd_pend;
  logic [PORTS-1:0] prev_wr_pend;
  logic             bank_open [BANKS];
  row_t             open_row  [BANKS];
  int               last_act  [BANKS];
  int               last_pre  [BANKS];
  int               last_ref;
  int               last_rw;
  int               last_rd;
  rd_win_t          rq [$];
  wr_beat_t         wq [$];

  sdram_sched_top #(
    .PORTS (PORTS)
  ) uut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .timing_i     (timing),
    .rd_req_i     (rd_req),
    .rd_addr_i    (rd_addr),
    .rd_rdy_o     (rd_rdy),
    .rd_data_o    (rd_data),
    .rd_valid_o   (rd_valid),
    .wr_req_i     (wr_req),
    .wr_addr_i    (wr_addr),
    .wr_data_i    (wr_data),
    .wr_be_i      (wr_be),
    .wr_rdy_o     (wr_rdy),
    .sdram_cmd_o  (sdram_cmd),
    .sdram_ba_o   (sdram_ba),
    .sdram_addr_o (sdram_addr),
    .sdram_dq_i   (dq_in),
    .sdram_dq_o   (dq_out),
    .sdram_dm_o   (dm_out),
    .sdram_dqoe_o (dqoe)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic flag_failure(input string msg);
    n_errors++;
    $display("ERROR at cycle %0d: %s", cyc, msg);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    n_errors++;
    $display("CHECK FAILED %s got %0h expected %0h at cycle %0d", name, got, exp, cyc);
  endtask

  function automatic logic ports_done();
    logic done;
    done = 1'b1;
    for (int p = 0; p < PORTS; p++)
    begin
      if (remaining[p] > 0 || kind[p] != K_NONE)
        done = 1'b0;
    end
    return done;
  endfunction

  ////////////////////
  // Stimulus
  ////////////////////

  // Two banks and four rows, so hits and misses both happen often
  task automatic new_request(input int p);
    logic [31:0] r;
    logic [31:0] idle_bits;
    r         = $random(seed);
    idle_bits = $random(seed);
    kind[p]            = r[0] ? K_WR : K_RD;
    cur_req[p].ba      = ba_t'(r[1]);
    cur_req[p].row     = row_t'(r[3:2]);
    cur_req[p].col     = r[13:4];
    // The address of the kind not requested holds unrelated bits
    rd_addr[p]         = r[0] ? req_t'(idle_bits[24:0]) : cur_req[p];
    wr_addr[p]         = r[0] ? cur_req[p] : req_t'(idle_bits[24:0]);
    wr_data[p][31:0]   = $random(seed);
    wr_data[p][63:32]  = $random(seed);
    wr_be[p]           = r[21:14];
    rd_req[p]          = !r[0];
    wr_req[p]          = r[0];
    waited[p]          = 0;
    remaining[p]--;
  endtask

  task automatic drive_ports();
    for (int p = 0; p < PORTS; p++)
    begin
      if (kind[p] != K_NONE)
      begin
        if (seen_rdy[p])
        begin
          seen_rdy[p] = 1'b0;
          kind[p]     = K_NONE;
          rd_req[p]   = 1'b0;
          wr_req[p]   = 1'b0;
          gap[p]      = $random(seed) & 3;
        end
        else if (waited[p] >= WAIT_LIMIT)
        begin
          flag_failure($sformatf("port %0d request was not accepted in time", p));
          aborted = 1'b1;
        end
        else
          waited[p]++;
      end
      if (kind[p] == K_NONE && remaining[p] > 0 && !aborted)
      begin
        if (gap[p] > 0)
          gap[p]--;
        else
          new_request(p);
      end
    end
    // Read data seen by the DUT on DQ
    dq_in = dq_t'($random(seed));
  endtask

  ////////////////////
  // Checks
  ////////////////////

  task automatic check_burst();
    logic             is_wr;
    logic [PORTS-1:0] rdy;
    logic [PORTS-1:0] other;
    logic [PORTS-1:0] hi_mask;
    int               p;
    int               b;
    req_t             r;
    rd_win_t          win;
    wr_beat_t         beat;
    is_wr = (sdram_cmd == CMD_WR);
    rdy   = is_wr ? wr_rdy : rd_rdy;
    other = is_wr ? rd_rdy : wr_rdy;
    p     = 0;
    for (int q = PORTS - 1; q >= 0; q--)
    begin
      if (rdy[q])
        p = q;
    end
    if ($countones(rdy) != 1 || other != '0)
      flag_failure("RD or WR without exactly one matching ready pulse");
    else
    begin
      r       = cur_req[p];
      b       = int'(r.ba);
      hi_mask = (PORTS'(1) << p) - 1'b1;
      if (is_wr && (prev_wr_pend & hi_mask) != '0)
        flag_failure("write granted ahead of a higher priority write");
      if (!is_wr && prev_wr_pend != '0)
        flag_failure("read granted while a write was waiting");
      if (!is_wr && (prev_rd_pend & hi_mask) != '0)
        flag_failure("read granted ahead of a higher priority read");
      if (sdram_ba !== r.ba)
        report_mismatch("sdram_ba_o", 32'(sdram_ba), 32'(r.ba));
      if (sdram_addr !== sdram_addr_t'(r.col))
        report_mismatch("sdram_addr_o", 32'(sdram_addr), 32'(r.col));
      if (!bank_open[b] || open_row[b] != r.row)
        flag_failure($sformatf("RD or WR to bank %0d whose row %0h is not open", b, r.row));
      if (cyc - last_act[b] < T_RCD)
        flag_failure($sformatf("ACT to RD or WR on bank %0d too soon", b));
      if (cyc - last_rw < BURST_LEN)
        flag_failure("RD or WR follows the previous burst too soon");
      if (is_wr && cyc - last_rd < BURST_LEN + T_CL)
        flag_failure("WR follows a RD too soon");
      if (is_wr)
      begin
        for (int k = 0; k < BURST_LEN; k++)
        begin
          beat.at = cyc + k;
          beat.dq = wr_data[p][k*DQ_W +: DQ_W];
          beat.dm = ~wr_be[p][k*$bits(dm_t) +: $bits(dm_t)];
          wq.push_back(beat);
        end
        n_writes++;
      end
      else
      begin
        win.start = cyc + T_CL + T_RDV;
        win.port  = p;
        rq.push_back(win);
        last_rd = cyc;
        n_reads++;
      end
      last_rw = cyc;
    end
  endtask

  task automatic check_command();
    int b;
    b = int'(sdram_ba);
    for (int p = 0; p < PORTS; p++)
    begin
      if ((rd_rdy[p] || wr_rdy[p]) && kind[p] == K_NONE)
        flag_failure($sformatf("port %0d ready pulse without a request", p));
      else if ((rd_rdy[p] && kind[p] != K_RD) || (wr_rdy[p] && kind[p] != K_WR))
        flag_failure($sformatf("port %0d ready pulse of the wrong kind", p));
      if (rd_rdy[p] || wr_rdy[p])
        seen_rdy[p] = 1'b1;
    end
    if ((rd_rdy != '0 || wr_rdy != '0) && sdram_cmd != CMD_RD && sdram_cmd != CMD_WR)
      flag_failure("ready pulse without a RD or WR command");

    case (sdram_cmd)
      CMD_NOP:
      begin
      end
      CMD_ACT:
      begin
        if (bank_open[b])
          flag_failure($sformatf("ACT to bank %0d which is already open", b));
        if (cyc - last_pre[b] < T_RP)
          flag_failure($sformatf("PRE to ACT on bank %0d too soon", b));
        if (cyc - last_ref < T_RC)
          flag_failure("REF to ACT too soon");
        bank_open[b] = 1'b1;
        open_row[b]  = sdram_addr;
        last_act[b]  = cyc;
      end
      CMD_PRE:
      begin
        for (int i = 0; i < BANKS; i++)
        begin
          if (sdram_addr[10] || i == b)
          begin
            if (!sdram_addr[10] && !bank_open[i])
              flag_failure($sformatf("PRE to bank %0d which is idle", i));
            if (bank_open[i] && cyc - last_act[i] < T_RAS)
              flag_failure($sformatf("ACT to PRE on bank %0d too soon", i));
            bank_open[i] = 1'b0;
            last_pre[i]  = cyc;
          end
        end
      end
      CMD_REF:
      begin
        for (int i = 0; i < BANKS; i++)
        begin
          if (bank_open[i])
            flag_failure($sformatf("REF while bank %0d is open", i));
        end
        if (cyc - last_ref < T_RC)
          flag_failure("REF to REF too soon");
        n_refs++;
        if (n_refs > (cyc - 2) / (T_REF + 1))
          flag_failure("more REF commands than refresh intervals");
        last_ref = cyc;
      end
      CMD_RD, CMD_WR:
        check_burst();
      default:
        report_mismatch("sdram_cmd_o", 32'(sdram_cmd), 32'(CMD_NOP));
    endcase
  endtask

  task automatic check_data();
    logic [PORTS-1:0] exp_valid;
    logic             exp_oe;
    exp_valid = '0;
    while (rq.size() > 0 && rq[0].start + BURST_LEN <= cyc)
      void'(rq.pop_front());
    foreach (rq[i])
    begin
      if (cyc >= rq[i].start && cyc < rq[i].start + BURST_LEN)
        exp_valid[rq[i].port] = 1'b1;
    end
    if (rd_valid !== exp_valid)
      report_mismatch("rd_valid_o", 32'(rd_valid), 32'(exp_valid));
    for (int p = 0; p < PORTS; p++)
    begin
      if (rd_valid[p] && rd_data[p] !== dq_in)
        report_mismatch("rd_data_o", 32'(rd_data[p]), 32'(dq_in));
    end

    exp_oe = (wq.size() > 0) && (wq[0].at == cyc);
    if (dqoe !== exp_oe)
      report_mismatch("sdram_dqoe_o", 32'(dqoe), 32'(exp_oe));
    if (exp_oe)
    begin
      if (dq_out !== wq[0].dq)
        report_mismatch("sdram_dq_o", 32'(dq_out), 32'(wq[0].dq));
      if (dm_out !== wq[0].dm)
        report_mismatch("sdram_dm_o", 32'(dm_out), 32'(wq[0].dm));
      void'(wq.pop_front());
    end
    if (dqoe && rd_valid != '0)
      flag_failure("write data driven while read data is valid");
  endtask

  // Outputs are settled by the falling edge
  always @(negedge clk_i)
  begin
    if (rst_ni)
    begin
      cyc++;
      check_command();
      check_data();
      for (int p = 0; p < PORTS; p++)
      begin
        prev_rd_pend[p] = (kind[p] == K_RD) && !rd_rdy[p];
        prev_wr_pend[p] = (kind[p] == K_WR) && !wr_rdy[p];
      end
    end
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial
  begin
    int guard;
    int intervals;
    rst_ni         = 1'b0;
    timing         = '0;
    timing.t_ras   = cnt_t'(T_RAS);
    timing.t_rp    = cnt_t'(T_RP);
    timing.t_rcd   = cnt_t'(T_RCD);
    timing.t_rc    = cnt_t'(T_RC);
    timing.cl      = cnt_t'(T_CL);
    timing.t_rdv   = cnt_t'(T_RDV);
    timing.t_ref   = 16'(T_REF);
    timing.ena     = 1'b1;
    rd_req         = '0;
    wr_req         = '0;
    dq_in          = '0;
    aborted        = 1'b0;
    cyc            = 0;
    n_errors       = 0;
    n_reads        = 0;
    n_writes       = 0;
    n_refs         = 0;
    prev_rd_pend   = '0;
    prev_wr_pend   = '0;
    last_ref       = -1000;
    last_rw        = -1000;
    last_rd        = -1000;
    for (int p = 0; p < PORTS; p++)
    begin
      rd_addr[p]   = '0;
      wr_addr[p]   = '0;
      wr_data[p]   = '0;
      wr_be[p]     = '0;
      cur_req[p]   = '0;
      kind[p]      = K_NONE;
      remaining[p] = N_TXN;
      gap[p]       = 0;
      waited[p]    = 0;
      seen_rdy[p]  = 1'b0;
    end
    for (int b = 0; b < BANKS; b++)
    begin
      bank_open[b] = 1'b0;
      open_row[b]  = '0;
      last_act[b]  = -1000;
      last_pre[b]  = -1000;
    end

    repeat (10) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    for (guard = 0; guard < RUN_LIMIT && !aborted && !ports_done(); guard++)
    begin
      @(posedge clk_i);
      #2;
      drive_ports();
    end
    if (!ports_done() && !aborted)
      flag_failure("stimulus did not finish within the run limit");

    // Let the last bursts leave the DQ pins
    for (guard = 0; guard < DRAIN_LIMIT && (rq.size() > 0 || wq.size() > 0); guard++)
      @(posedge clk_i);
    if (rq.size() > 0 || wq.size() > 0)
      flag_failure("read or write bursts still outstanding at the end");

    intervals = (cyc - 2) / (T_REF + 1);
    if (n_refs > intervals || n_refs < intervals - REF_SAT)
      flag_failure($sformatf("%0d REF commands for %0d refresh intervals", n_refs, intervals));

    $display("Reads %0d, writes %0d, refreshes %0d, errors %0d",
             n_reads, n_writes, n_refs, n_errors);
    if (n_errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
logic/sdram_sched_pkg.sv
logic/bank_timers.sv
logic/refresh_tracker.sv
logic/cmd_scheduler.sv
logic/rd_valid_pipe.sv
logic/wr_data_shifter.sv
logic/sdram_sched_top.sv
tb/tb_sdram_sched.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the SDRAM scheduler testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_sdram_sched
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_sdram_sched > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^NO ERRORS$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
